// File: source/rename_pkg.sv
// Register renaming package
package rename_pkg;

   // Architectural and physical register counts of the core.
   localparam int NUM_ARCH = 8;
   localparam int NUM_PHYS = 16;

   // Both rename and commit handle this many lanes per cycle.
   localparam int WIDTH = 2;

   // Physical registers not held by the committed map live in the free list.
   localparam int FREE_DEPTH = NUM_PHYS - NUM_ARCH;

   // Index bits of a free-list slot, without the wrap bit.
   localparam int FREE_IDX_W = $clog2(FREE_DEPTH);

   // Register numbers and free-list pointers.
   typedef logic [$clog2(NUM_ARCH)-1:0] arch_reg_t;
   typedef logic [$clog2(NUM_PHYS)-1:0] phys_reg_t;
   typedef logic [FREE_IDX_W:0]         free_ptr_t;

   // A whole alias table, one physical register per architectural register.
   typedef phys_reg_t [NUM_ARCH-1:0] arch_map_t;

   // Builds the map in which architectural register i sits in physical register i.
   function automatic arch_map_t identity_map();
      arch_map_t m;
      for (int i = 0; i < NUM_ARCH; i++) begin
         m[i] = phys_reg_t'(i);
      end
      return m;
   endfunction

   // Reset contents of both alias tables.
   localparam arch_map_t IDENTITY_MAP = identity_map();

endpackage

// File: source/alloc_if.sv
// Allocation interface
`timescale 1ns/1ps

interface alloc_if
   import rename_pkg::*;
();

   // One bit per lane.
   // A bit is set when the lane is valid and writes a destination.
   logic [WIDTH-1:0] need;

   // Next free registers in queue order, packed onto the lanes that need one.
   phys_reg_t [WIDTH-1:0] phys;

   // High when the queue cannot serve every need bit, and during a flush.
   // No lane renames while it is high.
   logic stall;

   // The alias table asks for registers.
   modport tbl (
      output need,
      input  phys,
      input  stall
   );

   // The free list hands them out.
   modport pool (
      input  need,
      output phys,
      output stall
   );

endinterface

// File: source/multi_write_regfile.sv
// Multi-port alias register file
`timescale 1ns/1ps

module multi_write_regfile
   import rename_pkg::*;
(
   input  logic                  CLK,
   input  logic                  RST,
   input  logic [WIDTH-1:0]      we,
   input  arch_reg_t [WIDTH-1:0] waddr,
   input  phys_reg_t [WIDTH-1:0] wdata,
   output arch_map_t             dout
);

   // One physical register number per architectural register.
   phys_reg_t regs [NUM_ARCH];

   // Reset loads the identity mapping into every entry.
   // Write ports are applied in index order.
   // When two ports hit the same entry the higher port is applied last, so it wins.
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         for (int j = 0; j < NUM_ARCH; j++) begin
            regs[j] <= IDENTITY_MAP[j];
         end
      end else begin
         for (int j = 0; j < WIDTH; j++) begin
            if (we[j]) begin
               regs[waddr[j]] <= wdata[j];
            end
         end
      end
   end

   // Every entry is visible at all times.
   // The committed map is copied whole on a flush and read per lane on a commit.
   generate
      for (genvar i = 0; i < NUM_ARCH; i++) begin : gen_dout
         assign dout[i] = regs[i];
      end
   endgenerate

endmodule

// File: source/spec_alias_table.sv
// Speculative alias table
`timescale 1ns/1ps

module spec_alias_table
   import rename_pkg::*;
(
   input  logic                  CLK,
   input  logic                  RST,
   input  logic                  flush,
   input  logic [WIDTH-1:0]      rename_valid,
   input  logic [WIDTH-1:0]      dst_valid,
   input  arch_reg_t [WIDTH-1:0] src1,
   input  arch_reg_t [WIDTH-1:0] src2,
   input  arch_reg_t [WIDTH-1:0] dst,
   alloc_if.tbl                  alloc,
   input  arch_map_t             committed_map,
   output phys_reg_t [WIDTH-1:0] phys_src1,
   output phys_reg_t [WIDTH-1:0] phys_src2,
   output phys_reg_t [WIDTH-1:0] phys_dst,
   output phys_reg_t [WIDTH-1:0] old_dst
);

   // The table is kept as one packed vector.
   // A flush then replaces it with the committed map in a single edge.
   arch_map_t spec_map;

   // Lanes that actually write the table this cycle.
   logic [WIDTH-1:0] table_we;

   // A lane asks the free list for a register when it is valid and has a destination.
   assign alloc.need = rename_valid & dst_valid;

   // The free list already raises stall during a flush.
   assign table_we = alloc.need & {WIDTH{~alloc.stall}};

   // New destinations come straight from the free list.
   assign phys_dst = alloc.phys;

   // Each lane first reads the table.
   // An earlier lane of the same group that writes the register then overrides the read.
   // Lanes are walked in order, so the latest earlier writer wins.
   always_comb begin
      for (int i = 0; i < WIDTH; i++) begin
         phys_src1[i] = spec_map[src1[i]];
         phys_src2[i] = spec_map[src2[i]];
         old_dst[i]   = spec_map[dst[i]];
         for (int j = 0; j < i; j++) begin
            if (alloc.need[j] && src1[i] == dst[j]) begin
               phys_src1[i] = alloc.phys[j];
            end
            if (alloc.need[j] && src2[i] == dst[j]) begin
               phys_src2[i] = alloc.phys[j];
            end
            // The old mapping of a repeated destination is the earlier lane's new register.
            if (alloc.need[j] && dst[i] == dst[j]) begin
               old_dst[i] = alloc.phys[j];
            end
         end
      end
   end

   // Flush restores the committed state and ignores rename.
   // Otherwise lanes are written in order, so lane 1 wins a shared destination.
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         spec_map <= IDENTITY_MAP;
      end else if (flush) begin
         spec_map <= committed_map;
      end else begin
         for (int i = 0; i < WIDTH; i++) begin
            if (table_we[i]) begin
               spec_map[dst[i]] <= alloc.phys[i];
            end
         end
      end
   end

   // A stalled cycle outside a flush leaves the table untouched at the next edge.
   assert property (@(posedge CLK) disable iff (!RST)
      alloc.stall && !flush |=> spec_map == $past(spec_map))
      else $error("speculative table written under stall");

endmodule

// File: source/free_list.sv
// Physical register free list
`timescale 1ns/1ps

module free_list
   import rename_pkg::*;
(
   input  logic                  CLK,
   input  logic                  RST,
   input  logic                  flush,
   alloc_if.pool                 alloc,
   input  logic [WIDTH-1:0]      rel_valid,
   input  phys_reg_t [WIDTH-1:0] rel_phys
);

   // Circular queue of register numbers.
   // Pointers carry one extra wrap bit so that full and empty differ.
   phys_reg_t queue [FREE_DEPTH];

   // The speculative head moves on rename.
   // The committed head trails it and moves on commit.
   // The tail moves as released registers are pushed.
   free_ptr_t spec_head;
   free_ptr_t commit_head;
   free_ptr_t tail;

   free_ptr_t free_count;
   free_ptr_t pop_count;
   free_ptr_t push_count;
   free_ptr_t push_ptr [WIDTH];

   // Entries between the speculative head and the tail are free.
   assign free_count = tail - spec_head;

   // Hand out head entries in queue order to the lanes that need one.
   // A lane without a need still sees the next entry but does not consume it.
   always_comb begin
      free_ptr_t rd;
      rd = spec_head;
      for (int i = 0; i < WIDTH; i++) begin
         alloc.phys[i] = queue[rd[FREE_IDX_W-1:0]];
         if (alloc.need[i]) begin
            rd = rd + 1'b1;
         end
      end
      pop_count = rd - spec_head;
   end

   // Not enough free entries for the whole group stalls every lane.
   // The flush cycle stalls too.
   assign alloc.stall = flush || (free_count < pop_count);

   // Released registers take consecutive tail slots in lane order.
   always_comb begin
      free_ptr_t wr;
      wr = tail;
      for (int i = 0; i < WIDTH; i++) begin
         push_ptr[i] = wr;
         if (rel_valid[i]) begin
            wr = wr + 1'b1;
         end
      end
      push_count = wr - tail;
   end

   // Every commit with a destination releases one register and also retires one allocation.
   // So the tail and the committed head advance by the same amount.
   // Flush rewinds the speculative head, which is safe since commit is idle then.
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         spec_head   <= '0;
         commit_head <= '0;
         tail        <= free_ptr_t'(FREE_DEPTH);
      end else begin
         tail        <= tail + push_count;
         commit_head <= commit_head + push_count;
         if (flush) begin
            spec_head <= commit_head;
         end else if (!alloc.stall) begin
            spec_head <= spec_head + pop_count;
         end
      end
   end

   // After reset the queue holds the registers above the identity map, in order.
   // A push lands on a slot the committed head has already passed.
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         for (int i = 0; i < FREE_DEPTH; i++) begin
            queue[i] <= phys_reg_t'(NUM_ARCH + i);
         end
      end else begin
         for (int i = 0; i < WIDTH; i++) begin
            if (rel_valid[i]) begin
               queue[push_ptr[i][FREE_IDX_W-1:0]] <= rel_phys[i];
            end
         end
      end
   end

   // The queue never claims more free entries than it has slots.
   assert property (@(posedge CLK) disable iff (!RST)
      free_count <= free_ptr_t'(FREE_DEPTH))
      else $error("free list over capacity");

   // Commits retire only what rename handed out, so the committed head stays behind.
   assert property (@(posedge CLK) disable iff (!RST)
      free_ptr_t'(spec_head - commit_head) <= free_ptr_t'(FREE_DEPTH))
      else $error("committed head passed speculative head");

endmodule

// File: source/commit_alias_table.sv
// Committed alias table
`timescale 1ns/1ps

module commit_alias_table
   import rename_pkg::*;
(
   input  logic                  CLK,
   input  logic                  RST,
   input  logic [WIDTH-1:0]      commit_valid,
   input  arch_reg_t [WIDTH-1:0] commit_arch,
   input  phys_reg_t [WIDTH-1:0] commit_phys,
   output arch_map_t             committed_map,
   output logic [WIDTH-1:0]      rel_valid,
   output phys_reg_t [WIDTH-1:0] rel_phys
);

   // Each committing lane writes its new mapping.
   // The register file lets lane 1 win when both lanes name one register.
   multi_write_regfile u_regfile (
      .CLK   (CLK),
      .RST   (RST),
      .we    (commit_valid),
      .waddr (commit_arch),
      .wdata (commit_phys),
      .dout  (committed_map)
   );

   // A commit with a destination always frees exactly one register.
   assign rel_valid = commit_valid;

   // The freed register is the mapping this lane replaces.
   // That is the current entry, unless an earlier lane of the same group just wrote it.
   // In that case the earlier lane's register is the one displaced.
   always_comb begin
      for (int i = 0; i < WIDTH; i++) begin
         rel_phys[i] = committed_map[commit_arch[i]];
         for (int j = 0; j < i; j++) begin
            if (commit_valid[j] && commit_arch[j] == commit_arch[i]) begin
               rel_phys[i] = commit_phys[j];
            end
         end
      end
   end

   // A released register must not be the one the same lane installs.
   generate
      for (genvar i = 0; i < WIDTH; i++) begin : gen_rel_chk
         assert property (@(posedge CLK) disable iff (!RST)
            rel_valid[i] |-> rel_phys[i] != commit_phys[i])
            else $error("lane %0d releases its own register", i);
      end
   endgenerate

endmodule

// File: source/rename_top.sv
// Register rename top level
`timescale 1ns/1ps

module rename_top
   import rename_pkg::*;
(
   input  logic                  CLK,
   input  logic                  RST,
   input  logic                  flush,
   input  logic [WIDTH-1:0]      rename_valid,
   input  logic [WIDTH-1:0]      dst_valid,
   input  arch_reg_t [WIDTH-1:0] src1,
   input  arch_reg_t [WIDTH-1:0] src2,
   input  arch_reg_t [WIDTH-1:0] dst,
   input  logic [WIDTH-1:0]      commit_valid,
   input  arch_reg_t [WIDTH-1:0] commit_arch,
   input  phys_reg_t [WIDTH-1:0] commit_phys,
   output phys_reg_t [WIDTH-1:0] phys_src1,
   output phys_reg_t [WIDTH-1:0] phys_src2,
   output phys_reg_t [WIDTH-1:0] phys_dst,
   output phys_reg_t [WIDTH-1:0] old_dst,
   output logic                  stall
);

   // Per-cycle allocation between the speculative table and the free list.
   alloc_if u_alloc ();

   // Release path from the committed table to the free list.
   logic [WIDTH-1:0]      rel_valid;
   phys_reg_t [WIDTH-1:0] rel_phys;

   // Whole committed map, copied into the speculative table on a flush.
   arch_map_t committed_map;

   spec_alias_table u_spec (
      .CLK           (CLK),
      .RST           (RST),
      .flush         (flush),
      .rename_valid  (rename_valid),
      .dst_valid     (dst_valid),
      .src1          (src1),
      .src2          (src2),
      .dst           (dst),
      .alloc         (u_alloc.tbl),
      .committed_map (committed_map),
      .phys_src1     (phys_src1),
      .phys_src2     (phys_src2),
      .phys_dst      (phys_dst),
      .old_dst       (old_dst)
   );

   // rel_valid follows commit_valid lane for lane.
   // It both pushes the freed registers and advances the committed head.
   free_list u_free (
      .CLK       (CLK),
      .RST       (RST),
      .flush     (flush),
      .alloc     (u_alloc.pool),
      .rel_valid (rel_valid),
      .rel_phys  (rel_phys)
   );

   commit_alias_table u_commit (
      .CLK           (CLK),
      .RST           (RST),
      .commit_valid  (commit_valid),
      .commit_arch   (commit_arch),
      .commit_phys   (commit_phys),
      .committed_map (committed_map),
      .rel_valid     (rel_valid),
      .rel_phys      (rel_phys)
   );

   assign stall = u_alloc.stall;

   // Flush rewinds to the committed state, which must not move in the same cycle.
   assert property (@(posedge CLK) disable iff (!RST)
      !(flush && |commit_valid))
      else $error("flush and commit in the same cycle");

endmodule

// File: tb/rename_tb.sv
// Register rename testbench
`timescale 1ns/1ps

module rename_tb
   import rename_pkg::*;
();

   localparam int WAIT_LIMIT = 20;

   logic                  CLK;
   logic                  RST;
   logic                  flush;
   logic [WIDTH-1:0]      rename_valid;
   logic [WIDTH-1:0]      dst_valid;
   arch_reg_t [WIDTH-1:0] src1;
   arch_reg_t [WIDTH-1:0] src2;
   arch_reg_t [WIDTH-1:0] dst;
   logic [WIDTH-1:0]      commit_valid;
   arch_reg_t [WIDTH-1:0] commit_arch;
   phys_reg_t [WIDTH-1:0] commit_phys;
   phys_reg_t [WIDTH-1:0] phys_src1;
   phys_reg_t [WIDTH-1:0] phys_src2;
   phys_reg_t [WIDTH-1:0] phys_dst;
   phys_reg_t [WIDTH-1:0] old_dst;
   logic                  stall;

   rename_top UUT (.*);

   // Reference model state.
   // Heads and tail count without wrapping, and the queue is indexed modulo its depth.
   phys_reg_t m_spec [NUM_ARCH];
   phys_reg_t m_com [NUM_ARCH];
   phys_reg_t m_queue [FREE_DEPTH];
   int        m_spec_head;
   int        m_commit_head;
   int        m_tail;

   // Renamed destinations that have not committed yet, oldest first.
   arch_reg_t pend_arch [$];
   phys_reg_t pend_phys [$];

   int          err_count;
   int          test_count;
   int          test_err_base;
   logic [31:0] seed;

   // Expected responses for the inputs of the current cycle.
   logic [WIDTH-1:0]      exp_need;
   logic                  exp_stall;
   phys_reg_t [WIDTH-1:0] exp_src1;
   phys_reg_t [WIDTH-1:0] exp_src2;
   phys_reg_t [WIDTH-1:0] exp_dst;
   phys_reg_t [WIDTH-1:0] exp_old;

   always #2 CLK = ~CLK;

   // Lookups read the table, then an older lane of the group that writes the register wins.
   // Each lane with a destination takes the next queue entry in order.
   always_comb begin
      int k;
      k = 0;
      exp_need = rename_valid & dst_valid;
      for (int i = 0; i < WIDTH; i++) begin
         exp_dst[i]  = m_queue[(m_spec_head + k) % FREE_DEPTH];
         exp_src1[i] = m_spec[src1[i]];
         exp_src2[i] = m_spec[src2[i]];
         exp_old[i]  = m_spec[dst[i]];
         for (int j = 0; j < i; j++) begin
            if (exp_need[j] && src1[i] == dst[j]) exp_src1[i] = exp_dst[j];
            if (exp_need[j] && src2[i] == dst[j]) exp_src2[i] = exp_dst[j];
            if (exp_need[j] && dst[i] == dst[j]) exp_old[i] = exp_dst[j];
         end
         if (exp_need[i]) k++;
      end
      exp_stall = flush || (m_tail - m_spec_head < k);
   end

   task automatic mismatch(string sig, int lane, int got, int want);
      err_count++;
      $display("MISMATCH t=%0t %s lane %0d: got %0d, expected %0d",
               $time, sig, lane, got, want);
   endtask

   // The DUT must agree with the model in every cycle after reset.
   assert property (@(posedge CLK) disable iff (!RST) stall == exp_stall)
      else mismatch("stall", 0, $sampled(stall), $sampled(exp_stall));

   generate
      for (genvar i = 0; i < WIDTH; i++) begin : gen_lane_chk
         assert property (@(posedge CLK) disable iff (!RST)
            !exp_stall && rename_valid[i] |-> phys_src1[i] == exp_src1[i])
            else mismatch("phys_src1", i, $sampled(phys_src1[i]), $sampled(exp_src1[i]));
         assert property (@(posedge CLK) disable iff (!RST)
            !exp_stall && rename_valid[i] |-> phys_src2[i] == exp_src2[i])
            else mismatch("phys_src2", i, $sampled(phys_src2[i]), $sampled(exp_src2[i]));
         assert property (@(posedge CLK) disable iff (!RST)
            !exp_stall && exp_need[i] |-> phys_dst[i] == exp_dst[i])
            else mismatch("phys_dst", i, $sampled(phys_dst[i]), $sampled(exp_dst[i]));
         assert property (@(posedge CLK) disable iff (!RST)
            !exp_stall && exp_need[i] |-> old_dst[i] == exp_old[i])
            else mismatch("old_dst", i, $sampled(old_dst[i]), $sampled(exp_old[i]));
      end
   endgenerate

   function automatic arch_reg_t rand_arch();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return arch_reg_t'(seed >> 16);
   endfunction

   // Applies the inputs of the cycle that ends at this edge to the model.
   // A commit frees what its register replaced, which is lane 0's register on a shared name.
   task automatic update_model();
      logic [WIDTH-1:0]      need_now;
      phys_reg_t [WIDTH-1:0] new_dst;
      logic                  stall_now;
      phys_reg_t             rel;
      need_now  = exp_need;
      new_dst   = exp_dst;
      stall_now = exp_stall;
      if (flush) begin
         for (int a = 0; a < NUM_ARCH; a++) begin
            m_spec[a] = m_com[a];
         end
         m_spec_head = m_commit_head;
         pend_arch.delete();
         pend_phys.delete();
      end else begin
         for (int i = 0; i < WIDTH; i++) begin
            if (!stall_now && need_now[i]) begin
               m_spec[dst[i]] = new_dst[i];
               pend_arch.push_back(dst[i]);
               pend_phys.push_back(new_dst[i]);
               m_spec_head++;
            end
         end
         for (int i = 0; i < WIDTH; i++) begin
            if (commit_valid[i]) begin
               rel = m_com[commit_arch[i]];
               m_com[commit_arch[i]] = commit_phys[i];
               m_queue[m_tail % FREE_DEPTH] = rel;
               m_tail++;
               m_commit_head++;
            end
         end
      end
   endtask

   task automatic next_cycle();
      @(posedge CLK);
      update_model();
   endtask

   // Random sources and destinations on the chosen lanes.
   task automatic drive_rename(logic [WIDTH-1:0] rv, logic [WIDTH-1:0] dv);
      arch_reg_t [WIDTH-1:0] s1;
      arch_reg_t [WIDTH-1:0] s2;
      arch_reg_t [WIDTH-1:0] d;
      for (int i = 0; i < WIDTH; i++) begin
         s1[i] = rand_arch();
         s2[i] = rand_arch();
         d[i]  = rand_arch();
      end
      rename_valid <= rv;
      dst_valid    <= dv;
      src1         <= s1;
      src2         <= s2;
      dst          <= d;
   endtask

   // Commits up to the given number of the oldest pending destinations.
   task automatic drive_commit(int lanes);
      logic [WIDTH-1:0]      cv;
      arch_reg_t [WIDTH-1:0] ca;
      phys_reg_t [WIDTH-1:0] cp;
      cv = '0;
      ca = '0;
      cp = '0;
      for (int i = 0; i < lanes && i < WIDTH; i++) begin
         if (pend_arch.size() > 0) begin
            cv[i] = 1'b1;
            ca[i] = pend_arch.pop_front();
            cp[i] = pend_phys.pop_front();
         end
      end
      commit_valid <= cv;
      commit_arch  <= ca;
      commit_phys  <= cp;
   endtask

   // Keeps driving until stall reaches the level, sampled away from the rising edge.
   task automatic wait_stall(logic level, logic [WIDTH-1:0] rv, logic [WIDTH-1:0] dv,
                             int lanes);
      logic hit;
      hit = 1'b0;
      for (int n = 0; n < WAIT_LIMIT && !hit; n++) begin
         drive_rename(rv, dv);
         drive_commit(lanes);
         @(negedge CLK);
         hit = (stall == level);
         next_cycle();
      end
      if (!hit) begin
         err_count++;
         $display("Timeout at t=%0t: stall never became %0b", $time, level);
      end
   endtask

   task automatic finish_test(string name);
      test_count++;
      $display("Test %0d %s: %0d errors", test_count, name, err_count - test_err_base);
      test_err_base = err_count;
   endtask

   // Watchdog for the whole run.
   initial begin
      #20000;
      $display("Timeout: the simulation did not finish in time");
      $display("Something failed");
      $finish;
   end

   initial begin
      CLK = 1'b0;
      RST = 1'b0;
      flush = 1'b0;
      rename_valid = '0;
      dst_valid = '0;
      src1 = '0;
      src2 = '0;
      dst = '0;
      commit_valid = '0;
      commit_arch = '0;
      commit_phys = '0;
      seed = 32'he17900b9;
      err_count = 0;
      test_count = 0;
      test_err_base = 0;
      for (int a = 0; a < NUM_ARCH; a++) begin
         m_spec[a] = phys_reg_t'(a);
         m_com[a]  = phys_reg_t'(a);
      end
      for (int i = 0; i < FREE_DEPTH; i++) begin
         m_queue[i] = phys_reg_t'(NUM_ARCH + i);
      end
      m_spec_head = 0;
      m_commit_head = 0;
      m_tail = FREE_DEPTH;
      repeat (3) @(posedge CLK);
      RST <= 1'b1;

      // Lookups only, so every source maps to itself.
      repeat (6) begin
         drive_rename(2'b11, 2'b00);
         next_cycle();
      end
      finish_test("reset lookups");

      // Lane 0 twice, then lane 1 alone, which takes the head register.
      repeat (2) begin
         drive_rename(2'b01, 2'b01);
         next_cycle();
      end
      drive_rename(2'b10, 2'b10);
      next_cycle();
      repeat (6) begin
         drive_rename(2'b11, 2'b00);
         next_cycle();
      end
      finish_test("allocation order");

      // Lane 1 reads and rewrites the register lane 0 writes.
      rename_valid <= 2'b11;
      dst_valid    <= 2'b11;
      src1         <= {arch_reg_t'(3), arch_reg_t'(1)};
      src2         <= {arch_reg_t'(3), arch_reg_t'(2)};
      dst          <= {arch_reg_t'(3), arch_reg_t'(3)};
      next_cycle();
      dst_valid <= 2'b00;
      src1      <= {arch_reg_t'(3), arch_reg_t'(3)};
      next_cycle();
      finish_test("group bypass");

      // Run the queue dry, then hold the stall and look up again.
      wait_stall(1'b1, 2'b11, 2'b11, 0);
      repeat (2) begin
         drive_rename(2'b11, 2'b11);
         next_cycle();
      end
      drive_rename(2'b11, 2'b00);
      next_cycle();
      finish_test("stall");

      // Commits refill the queue behind the registers still free.
      wait_stall(1'b0, 2'b11, 2'b11, 1);
      // Drain the pending commits while only looking registers up.
      for (int n = 0; n < WAIT_LIMIT && pend_arch.size() > 0; n++) begin
         drive_rename(2'b11, 2'b00);
         drive_commit(2);
         next_cycle();
      end
      if (pend_arch.size() > 0) begin
         err_count++;
         $display("Timeout at t=%0t: pending commits did not drain", $time);
      end
      repeat (4) begin
         drive_rename(2'b11, 2'b11);
         drive_commit(1);
         next_cycle();
      end
      finish_test("commit release");

      // Leave renames uncommitted, then flush while rename inputs are active.
      drive_commit(0);
      drive_rename(2'b11, 2'b11);
      next_cycle();
      drive_rename(2'b11, 2'b11);
      flush <= 1'b1;
      next_cycle();
      flush <= 1'b0;
      wait_stall(1'b0, 2'b11, 2'b00, 0);
      repeat (3) begin
         drive_rename(2'b11, 2'b11);
         next_cycle();
      end
      finish_test("flush");

      drive_rename(2'b00, 2'b00);
      drive_commit(0);
      next_cycle();
      @(negedge CLK);
      $display("Tests run: %0d, errors: %0d", test_count, err_count);
      if (err_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: project.f
source/rename_pkg.sv
source/alloc_if.sv
source/multi_write_regfile.sv
source/spec_alias_table.sv
source/free_list.sv
source/commit_alias_table.sv
source/rename_top.sv
tb/rename_tb.sv

// File: run.sh
#!/bin/sh
# Builds the rename testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module rename_tb -f project.f -o rename_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/rename_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Everything OK$" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1
